// ==== rtl/fsrc_pkg.sv ====
package fsrc_pkg;

  //////////////////////////////
  // Stream geometry
  //////////////////////////////

  localparam int num_channels     = 2;
  localparam int samples_per_word = 4;
  localparam int sample_width     = 16;
  localparam int phase_width      = 16;

  // Shift store depth per channel, in samples
  localparam int store_words = 3;
  localparam int store_depth = store_words * samples_per_word;

  // Counter widths derived from the above
  localparam int used_width = $clog2(samples_per_word + 1);
  localparam int fill_width = $clog2(store_depth + 1);

  //////////////////////////////
  // APB register map
  //////////////////////////////

  localparam int addr_width = 4;
  localparam int data_width = 32;

  localparam logic [addr_width-1:0] addr_ctrl  = 4'h0;
  localparam logic [addr_width-1:0] addr_step  = 4'h4;
  localparam logic [addr_width-1:0] addr_hole  = 4'h8;
  localparam logic [addr_width-1:0] addr_count = 4'hC;

  // Bit position of enable inside ctrl
  localparam int ctrl_enable_bit = 0;

  //////////////////////////////
  // Payload types
  //////////////////////////////

  typedef logic [sample_width-1:0] sample_t;

  // Indexed as [channel][slot]
  typedef sample_t [num_channels-1:0][samples_per_word-1:0] word_t;

  // One flag per slot, 1 means hole
  typedef logic [samples_per_word-1:0] mask_t;

endpackage

// ==== rtl/fsrc_apb_regs.sv ====
`timescale 1ns/1ps

module fsrc_apb_regs (
  input  logic                             clk,
  input  logic                             reset,

  input  logic [fsrc_pkg::addr_width-1:0]  paddr,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [fsrc_pkg::data_width-1:0]  pwdata,
  output logic [fsrc_pkg::data_width-1:0]  prdata,
  output logic                             pready,
  output logic                             pslverr,

  input  logic                             out_valid,
  input  logic                             out_ready,

  output logic                             enable,
  output logic [fsrc_pkg::phase_width-1:0] step,
  output fsrc_pkg::sample_t                hole_value
);

  import fsrc_pkg::*;

  logic                  access;
  logic                  addr_known;
  logic                  wr_ok;
  logic [data_width-1:0] count;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  assign access = psel && penable;

  always_comb begin
    case (paddr)
      addr_ctrl, addr_step, addr_hole, addr_count: addr_known = 1'b1;
      default:                                     addr_known = 1'b0;
    endcase
  end

  // No wait states
  assign pready = 1'b1;

  // Count is read only
  assign pslverr = access && (!addr_known || (pwrite && paddr == addr_count));

  assign wr_ok = access && pwrite && !pslverr;

  //////////////////////////////
  // Configuration registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      enable     <= 1'b0;
      step       <= '0;
      hole_value <= '0;
    end else if (wr_ok) begin
      case (paddr)
        addr_ctrl: enable     <= pwdata[ctrl_enable_bit];
        addr_step: step       <= pwdata[phase_width-1:0];
        addr_hole: hole_value <= pwdata[sample_width-1:0];
        default: ;
      endcase
    end
  end

  // Delivered output words, wraps naturally
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (out_valid && out_ready) begin
      count <= count + 1'b1;
    end
  end

  // Read mux
  always_comb begin
    case (paddr)
      addr_ctrl:  prdata = data_width'(enable) << ctrl_enable_bit;
      addr_step:  prdata = data_width'(step);
      addr_hole:  prdata = data_width'(hole_value);
      addr_count: prdata = count;
      default:    prdata = '0;
    endcase
  end

  // Access phase only ever follows a selected setup phase
  a_penable_needs_psel: assert property (
    @(posedge clk) disable iff (reset) penable |-> psel
  );

endmodule

// ==== rtl/fsrc_hole_gen.sv ====
`timescale 1ns/1ps

module fsrc_hole_gen (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             enable,
  input  logic [fsrc_pkg::phase_width-1:0] step,

  output logic                             mask_valid,
  input  logic                             mask_ready,
  output fsrc_pkg::mask_t                  mask
);

  import fsrc_pkg::*;

  logic [phase_width-1:0] acc;
  logic [phase_width-1:0] phase_chain [samples_per_word+1];
  mask_t                  carry;
  logic                   load;

  //////////////////////////////
  // Step chain, one add per slot
  //////////////////////////////

  assign phase_chain[0] = acc;

  for (genvar k = 0; k < samples_per_word; k++) begin : g_slot
    // Carry out of the 16-bit add marks a real sample
    assign {carry[k], phase_chain[k+1]} = phase_chain[k] + step;
  end

  // New mask when the register is empty or its mask was just taken
  assign load = !mask_valid || (mask_valid && mask_ready);

  //////////////////////////////
  // Phase accumulator and mask register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || !enable) begin
      acc        <= '0;
      mask_valid <= 1'b0;
    end else if (load) begin
      acc        <= phase_chain[samples_per_word];
      mask_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (enable && load) begin
      // No carry means hole
      mask <= ~carry;
    end
  end

  // Offered mask holds until make_holes takes it
  a_mask_stable: assert property (
    @(posedge clk) disable iff (reset)
    mask_valid && !mask_ready |=> $stable(mask)
  );

endmodule

// ==== rtl/fsrc_make_holes.sv ====
`timescale 1ns/1ps

module fsrc_make_holes (
  input  logic              clk,
  input  logic              reset,

  input  logic              in_valid,
  output logic              in_ready,
  input  fsrc_pkg::word_t   in_data,

  input  logic              mask_valid,
  output logic              mask_ready,
  input  fsrc_pkg::mask_t   mask,

  input  fsrc_pkg::sample_t hole_value,

  output logic              out_valid,
  input  logic              out_ready,
  output fsrc_pkg::word_t   out_data
);

  import fsrc_pkg::*;

  logic                                         in_xfer;
  logic                                         in_hold_valid;
  word_t                                        in_hold;
  logic                                         shift_in;

  logic                                         mask_xfer;
  logic                                         mask_hold_valid;
  mask_t                                        mask_hold;
  logic                                         mask_use;

  sample_t [num_channels-1:0][store_depth-1:0]  store;
  sample_t [num_channels-1:0][store_depth-1:0]  store_next;
  logic [fill_width-1:0]                        fill;
  logic [fill_width-1:0]                        fill_next;
  logic [fill_width-1:0]                        remaining;

  logic [used_width-1:0]                        used;
  logic [used_width-1:0]                        used_eff;
  logic [samples_per_word-1:0][used_width-1:0]  slot_pos;
  word_t                                        word_next;
  logic                                         out_free;

  //////////////////////////////
  // Input stage
  //////////////////////////////

  assign in_xfer  = in_valid && in_ready;
  assign shift_in = in_hold_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_hold_valid <= 1'b0;
    end else if (in_xfer) begin
      in_hold_valid <= 1'b1;
    end else if (shift_in) begin
      in_hold_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      in_hold <= in_data;
    end
  end

  //////////////////////////////
  // Mask stage
  //////////////////////////////

  assign out_free   = !out_valid || out_ready;
  // Build a word once enough samples wait and the output can take it
  assign mask_use   = mask_hold_valid && (fill >= fill_width'(samples_per_word)) && out_free;
  assign mask_ready = !mask_hold_valid || mask_use;
  assign mask_xfer  = mask_valid && mask_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      mask_hold_valid <= 1'b0;
    end else if (mask_xfer) begin
      mask_hold_valid <= 1'b1;
    end else if (mask_use) begin
      mask_hold_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (mask_xfer) begin
      mask_hold <= mask;
    end
  end

  // Running count of non-holes gives each slot its store index
  always_comb begin
    used = '0;
    for (int j = 0; j < samples_per_word; j++) begin
      slot_pos[j] = used;
      used = used + used_width'(!mask_hold[j]);
    end
  end

  always_comb begin
    for (int c = 0; c < num_channels; c++) begin
      for (int j = 0; j < samples_per_word; j++) begin
        word_next[c][j] = mask_hold[j] ? hole_value : store[c][slot_pos[j]];
      end
    end
  end

  //////////////////////////////
  // Shift store
  //////////////////////////////

  always_comb begin
    int off;
    used_eff  = mask_use ? used : '0;
    remaining = fill - fill_width'(used_eff);
    fill_next = remaining + (shift_in ? fill_width'(samples_per_word) : '0);
    for (int c = 0; c < num_channels; c++) begin
      for (int i = 0; i < store_depth; i++) begin
        off = i - int'(remaining);
        if (i < int'(remaining)) begin
          // Survivors slide down past the used samples
          store_next[c][i] = store[c][i + int'(used_eff)];
        end else if (shift_in && off < samples_per_word) begin
          store_next[c][i] = in_hold[c][off];
        end else begin
          store_next[c][i] = store[c][i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    store <= store_next;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fill     <= '0;
      in_ready <= 1'b0;
    end else begin
      fill     <= fill_next;
      // Room for one more word only up to two words stored
      in_ready <= fill_next <= fill_width'(2 * samples_per_word);
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (mask_use) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (mask_use) begin
      out_data <= word_next;
    end
  end

  a_fill_bound: assert property (
    @(posedge clk) disable iff (reset) fill <= fill_width'(store_depth)
  );

  a_out_hold: assert property (
    @(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  );

endmodule

// ==== rtl/fsrc_tx_top.sv ====
`timescale 1ns/1ps

module fsrc_tx_top (
  input  logic                            clk,
  input  logic                            reset,

  // APB slave
  input  logic [fsrc_pkg::addr_width-1:0] paddr,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [fsrc_pkg::data_width-1:0] pwdata,
  output logic [fsrc_pkg::data_width-1:0] prdata,
  output logic                            pready,
  output logic                            pslverr,

  // Dense sample input
  input  logic                            in_valid,
  output logic                            in_ready,
  input  fsrc_pkg::word_t                 in_data,

  // Output with holes
  output logic                            out_valid,
  input  logic                            out_ready,
  output fsrc_pkg::word_t                 out_data
);

  import fsrc_pkg::*;

  logic                   enable;
  logic [phase_width-1:0] step;
  sample_t                hole_value;
  logic                   mask_valid;
  logic                   mask_ready;
  mask_t                  mask;

  fsrc_apb_regs u_fsrc_apb_regs (
    .clk        (clk),
    .reset      (reset),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .enable     (enable),
    .step       (step),
    .hole_value (hole_value)
  );

  fsrc_hole_gen u_fsrc_hole_gen (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .step       (step),
    .mask_valid (mask_valid),
    .mask_ready (mask_ready),
    .mask       (mask)
  );

  fsrc_make_holes u_fsrc_make_holes (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .mask_valid (mask_valid),
    .mask_ready (mask_ready),
    .mask       (mask),
    .hole_value (hole_value),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data)
  );

endmodule

// ==== sim/fsrc_checker.sv ====
`timescale 1ns/1ps

module fsrc_checker (
  input  logic                            clk,
  input  logic                            reset,

  input  logic [fsrc_pkg::addr_width-1:0] paddr,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [fsrc_pkg::data_width-1:0] pwdata,
  input  logic [fsrc_pkg::data_width-1:0] prdata,
  input  logic                            pready,
  input  logic                            pslverr,

  input  logic                            in_valid,
  input  logic                            in_ready,
  input  fsrc_pkg::word_t                 in_data,
  input  logic                            out_valid,
  input  logic                            out_ready,
  input  fsrc_pkg::word_t                 out_data,

  input  logic                            expect_idle,
  output int                              error_count,
  output int                              word_count
);

  import fsrc_pkg::*;

  logic                   enable_m;
  logic [phase_width-1:0] step_m;
  sample_t                hole_m;
  logic [phase_width-1:0] acc_m;
  logic [data_width-1:0]  count_m;
  logic                   exp_err;
  sample_t                q [num_channels][$];
  int                     errors = 0;
  int                     words = 0;

  assign error_count = errors;
  assign word_count  = words;

  function automatic logic [data_width-1:0] reg_value(input logic [addr_width-1:0] a);
    case (a)
      addr_ctrl:  return data_width'(enable_m);
      addr_step:  return data_width'(step_m);
      addr_hole:  return data_width'(hole_m);
      addr_count: return count_m;
      default:    return '0;
    endcase
  endfunction

  //////////////////////////////
  // Hole rule model
  //////////////////////////////

  task automatic check_word();
    logic [phase_width:0] sum;
    mask_t                hole;
    sample_t              exp;
    // Four step additions where a carry out marks a real sample
    for (int k = 0; k < samples_per_word; k++) begin
      sum     = {1'b0, acc_m} + {1'b0, step_m};
      hole[k] = !sum[phase_width];
      acc_m   = sum[phase_width-1:0];
    end
    for (int c = 0; c < num_channels; c++) begin
      for (int k = 0; k < samples_per_word; k++) begin
        exp = hole_m;
        if (!hole[k]) begin
          if (q[c].size() == 0) begin
            $display("Output word %0d at %0t takes a channel %0d sample that never arrived",
                     words, $time, c);
            errors++;
          end else begin
            exp = q[c].pop_front();
          end
        end
        if (out_data[c][k] !== exp) begin
          $display("ERR %0t out_data[%0d][%0d] expected %h got %h",
                   $time, c, k, exp, out_data[c][k]);
          errors++;
        end
      end
    end
  endtask

  //////////////////////////////
  // Bus watch
  //////////////////////////////

  always @(posedge clk) begin
    if (reset) begin
      // Both streams stay closed while reset is held
      if (in_ready === 1'b1 || out_valid === 1'b1) begin
        $display("Stream handshake raised at %0t while reset was held", $time);
        errors++;
      end
      enable_m = 1'b0;
      step_m   = '0;
      hole_m   = '0;
      acc_m    = '0;
      count_m  = '0;
      for (int c = 0; c < num_channels; c++) begin
        q[c].delete();
      end
    end else begin
      // APB first so a count read sees the value before this edge
      if (psel && penable) begin
        if (pready !== 1'b1) begin
          $display("ERR %0t pready expected 1 got %b", $time, pready);
          errors++;
        end
        exp_err = !(paddr inside {addr_ctrl, addr_step, addr_hole, addr_count}) ||
                  (pwrite && paddr == addr_count);
        if (pslverr !== exp_err) begin
          $display("ERR %0t pslverr expected %b got %b", $time, exp_err, pslverr);
          errors++;
        end
        if (!pwrite && !exp_err && prdata !== reg_value(paddr)) begin
          $display("ERR %0t prdata expected %h got %h", $time, reg_value(paddr), prdata);
          errors++;
        end
        if (pwrite && !exp_err) begin
          case (paddr)
            addr_ctrl: begin
              // Phase restarts from zero on every enable
              if (pwdata[0] && !enable_m) begin
                acc_m = '0;
              end
              enable_m = pwdata[0];
            end
            addr_step: step_m = pwdata[phase_width-1:0];
            addr_hole: hole_m = pwdata[sample_width-1:0];
            default: ;
          endcase
        end
      end
      if (in_valid && in_ready) begin
        for (int c = 0; c < num_channels; c++) begin
          for (int k = 0; k < samples_per_word; k++) begin
            q[c].push_back(in_data[c][k]);
          end
        end
      end
      if (out_valid && out_ready) begin
        check_word();
        words++;
        count_m = count_m + 32'd1;
      end
      if (expect_idle && out_valid) begin
        $display("Output word offered at %0t while the converter was disabled and drained",
                 $time);
        errors++;
      end
    end
  end

endmodule

// ==== sim/tb_fsrc_tx.sv ====
`timescale 1ns/1ps

module tb_fsrc_tx;

  import fsrc_pkg::*;

  localparam int test_words     = 200 + 5 * 100 + 300;
  localparam int timeout_cycles = test_words * 20 + 2000;

  logic                  clk = 1'b0;
  logic                  reset;
  logic [addr_width-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [data_width-1:0] pwdata;
  logic [data_width-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  in_valid = 1'b0;
  logic                  in_ready;
  word_t                 in_data = '0;
  logic                  out_valid;
  logic                  out_ready = 1'b0;
  word_t                 out_data;
  logic                  in_taken = 1'b0;
  logic                  expect_idle;
  int                    error_count;
  int                    word_count;
  int                    in_rate;
  int                    out_rate;
  int                    cycles = 0;
  int                    tests_run = 0;
  int                    tests_failed = 0;
  int                    errors_before = 0;

  fsrc_tx_top u_fsrc_tx_top (
    .clk(clk), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
    .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
  );

  fsrc_checker u_fsrc_checker (
    .clk(clk), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
    .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
    .expect_idle(expect_idle), .error_count(error_count), .word_count(word_count)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    in_taken <= in_valid && in_ready;
    cycles   <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout after %0d cycles, output words stopped arriving", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Random input words and back-pressure where a pending word holds until taken
  always @(negedge clk) begin
    if (!reset) begin
      if (!in_valid || in_taken) begin
        in_valid <= ($urandom % 100) < in_rate;
        for (int c = 0; c < num_channels; c++) begin
          for (int k = 0; k < samples_per_word; k++) begin
            in_data[c][k] <= 16'($urandom);
          end
        end
      end
      out_ready <= ($urandom % 100) < out_rate;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic apb_access(input logic write, input logic [addr_width-1:0] addr,
                            input logic [data_width-1:0] data);
    @(negedge clk);
    paddr   = addr;
    pwrite  = write;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    while (!pready) @(posedge clk);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_words(input int n);
    int target;
    target = word_count + n;
    while (word_count < target) @(negedge clk);
  endtask

  // Held mask still needs samples so input keeps flowing until the output is quiet
  task automatic disable_and_drain();
    int quiet;
    in_rate  = 100;
    out_rate = 100;
    apb_access(1'b1, addr_ctrl, 32'd0);
    quiet = 0;
    while (quiet < 16) begin
      @(negedge clk);
      quiet = out_valid ? 0 : quiet + 1;
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = error_count - errors_before;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("Test %0d %s: %s, %0d errors", tests_run, name, errs == 0 ? "pass" : "fail", errs);
    errors_before = error_count;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    void'($urandom(72));
    reset       = 1'b1;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    expect_idle = 1'b0;
    in_rate     = 100;
    out_rate    = 100;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    apb_access(1'b0, addr_ctrl, '0);
    apb_access(1'b0, addr_step, '0);
    apb_access(1'b0, addr_hole, '0);
    apb_access(1'b0, addr_count, '0);
    apb_access(1'b1, addr_step, 32'h0000_1234);
    apb_access(1'b1, addr_hole, 32'h0000_5A5A);
    apb_access(1'b1, addr_ctrl, 32'd1);
    apb_access(1'b0, addr_step, '0);
    apb_access(1'b0, addr_hole, '0);
    apb_access(1'b0, addr_ctrl, '0);
    apb_access(1'b1, 4'h2, 32'hFFFF_FFFF);
    apb_access(1'b0, 4'h6, '0);
    apb_access(1'b1, addr_count, 32'h0000_00AA);
    disable_and_drain();
    apb_access(1'b0, addr_count, '0);
    end_test("registers");

    apb_access(1'b1, addr_hole, 32'h0000_DEAD);
    apb_access(1'b1, addr_step, 32'h0000_8000);
    apb_access(1'b1, addr_ctrl, 32'd1);
    wait_words(200);
    end_test("half rate");

    repeat (5) begin
      disable_and_drain();
      apb_access(1'b1, addr_step, data_width'(16'($urandom)));
      apb_access(1'b1, addr_ctrl, 32'd1);
      wait_words(100);
    end
    end_test("random rates");

    disable_and_drain();
    apb_access(1'b1, addr_step, data_width'(16'($urandom)));
    in_rate  = 50;
    out_rate = 50;
    apb_access(1'b1, addr_ctrl, 32'd1);
    wait_words(300);
    end_test("back-pressure and gaps");

    disable_and_drain();
    expect_idle = 1'b1;
    repeat (50) @(negedge clk);
    expect_idle = 1'b0;
    apb_access(1'b0, addr_count, '0);
    end_test("disable and count");

    $display("Tests run %0d, failed %0d, words checked %0d, errors %0d",
             tests_run, tests_failed, word_count, error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
rtl/fsrc_pkg.sv
rtl/fsrc_apb_regs.sv
rtl/fsrc_hole_gen.sv
rtl/fsrc_make_holes.sv
rtl/fsrc_tx_top.sv
sim/fsrc_checker.sv
sim/tb_fsrc_tx.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fractional rate converter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fsrc_tx -f files.f -o sim_fsrc_tx

output=$(./obj_dir/sim_fsrc_tx)
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
